/* logic/frontend_pkg.sv */
package frontend_pkg;

    //////////////////////////////////////////////////////////////////////
    // Widths and depths
    //////////////////////////////////////////////////////////////////////

    // One instruction, also one byte address
    localparam int INST_W = 32;

    // One memory word holds an instruction pair
    localparam int PAIR_W = 64;

    localparam int MEM_DEPTH = 256;
    localparam int MEM_AW    = 8;

    // Instruction buffer
    localparam int IBUF_DEPTH = 16;
    localparam int IBUF_AW    = 4;
    localparam int IBUF_CW    = 5;

    // Fetch restarts here out of reset
    localparam logic [INST_W-1:0] BOOT_PC = '0;

    //////////////////////////////////////////////////////////////////////
    // Encodings
    //////////////////////////////////////////////////////////////////////

    // Major opcode, instruction bits 31..26
    // Branch offset lives in bits 15..0, counted in instructions
    typedef enum logic [5:0] {
        OP_OTHER = 6'h00,
        OP_JUMP  = 6'h02,
        OP_BCOND = 6'h04
    } opcode_e;

    // Fetch sequencing
    typedef enum logic [1:0] {
        IDLE,
        REQ,
        WAIT
    } fetch_state_e;

endpackage

/* logic/inst_mem.sv */
`timescale 1ns/1ps

module inst_mem
    import frontend_pkg::*;
(
    input  logic              clk,
    input  logic              en_i,
    input  logic              we_i,
    input  logic [MEM_AW-1:0] addr_i,
    input  logic [PAIR_W-1:0] wdata_i,
    output logic [PAIR_W-1:0] rdata_o
);

    // Pair storage
    // Lower half is the instruction at the even address
    logic [PAIR_W-1:0] mem_q [MEM_DEPTH];

    // Single port, write or read in a given cycle
    always_ff @(posedge clk) begin
        if (en_i) begin
            if (we_i) begin
                mem_q[addr_i] <= wdata_i;
            end else begin
                // Read data shows up one cycle later
                rdata_o <= mem_q[addr_i];
            end
        end
    end

endmodule

/* logic/mem_arbiter.sv */
`timescale 1ns/1ps

module mem_arbiter
    import frontend_pkg::*;
(
    input  logic              clk,
    input  logic              reset_i,

    // Program load port
    input  logic              load_valid_i,
    output logic              load_ready_o,
    input  logic [MEM_AW-1:0] load_addr_i,
    input  logic [PAIR_W-1:0] load_data_i,

    // Fetch request and response
    input  logic              fetch_req_valid_i,
    output logic              fetch_req_ready_o,
    input  logic [MEM_AW-1:0] fetch_req_addr_i,
    output logic              fetch_rsp_valid_o,
    output logic [PAIR_W-1:0] fetch_rsp_data_o,

    // Memory side
    output logic              mem_en_o,
    output logic              mem_we_o,
    output logic [MEM_AW-1:0] mem_addr_o,
    output logic [PAIR_W-1:0] mem_wdata_o,
    input  logic [PAIR_W-1:0] mem_rdata_i
);

    logic fetch_grant;
    logic rd_pend_q;

    // Loads have fixed priority, so the load side never waits
    assign load_ready_o      = 1'b1;
    assign fetch_req_ready_o = !load_valid_i;
    assign fetch_grant       = fetch_req_valid_i && !load_valid_i;

    // Port steering
    assign mem_en_o    = load_valid_i || fetch_req_valid_i;
    assign mem_we_o    = load_valid_i;
    assign mem_addr_o  = load_valid_i ? load_addr_i : fetch_req_addr_i;
    assign mem_wdata_o = load_data_i;

    // Remember a fetch read so its data can be tagged next cycle
    always_ff @(posedge clk) begin
        if (reset_i) begin
            rd_pend_q <= 1'b0;
        end else begin
            rd_pend_q <= fetch_grant;
        end
    end

    // Read data goes straight back to fetch
    assign fetch_rsp_valid_o = rd_pend_q;
    assign fetch_rsp_data_o  = mem_rdata_i;

endmodule

/* logic/fetch_unit.sv */
`timescale 1ns/1ps

module fetch_unit
    import frontend_pkg::*;
(
    input  logic               clk,
    input  logic               reset_i,
    input  logic               run_i,
    input  logic               flush_i,
    input  logic [INST_W-1:0]  flush_pc_i,

    output logic               fetch_req_valid_o,
    input  logic               fetch_req_ready_i,
    output logic [MEM_AW-1:0]  fetch_req_addr_o,
    input  logic               fetch_rsp_valid_i,
    input  logic [PAIR_W-1:0]  fetch_rsp_data_i,

    input  logic [IBUF_CW-1:0] ibuf_count_i,

    output logic               wr0_en_o,
    output logic [INST_W-1:0]  wr0_inst_o,
    output logic [INST_W-1:0]  wr0_pc_o,
    output logic               wr0_is_branch_o,
    output logic               wr0_pred_taken_o,
    output logic [INST_W-1:0]  wr0_pred_target_o,
    output logic               wr1_en_o,
    output logic [INST_W-1:0]  wr1_inst_o,
    output logic [INST_W-1:0]  wr1_pc_o,
    output logic               wr1_is_branch_o,
    output logic               wr1_pred_taken_o,
    output logic [INST_W-1:0]  wr1_pred_target_o
);

    fetch_state_e state_q;
    fetch_state_e state_d;

    logic [INST_W-1:0] pc_q;
    logic [INST_W-1:0] next_pc;
    logic              rsp_take;
    logic              skip0;
    logic              credit_idle;
    logic              credit_wait;

    // Predecode of both halves of the returned pair
    logic [INST_W-1:0] slot_inst [2];
    logic [INST_W-1:0] slot_pc   [2];
    logic [INST_W-1:0] slot_tgt  [2];
    logic [1:0]        slot_br;
    logic [1:0]        slot_tk;

    function automatic opcode_e decode_op(input logic [5:0] bits);
        case (bits)
            OP_JUMP:  decode_op = OP_JUMP;
            OP_BCOND: decode_op = OP_BCOND;
            default:  decode_op = OP_OTHER;
        endcase
    endfunction

    //////////////////////////////////////////////////////////////////////
    // Predecode and static prediction
    //////////////////////////////////////////////////////////////////////

    always_comb begin
        for (int s = 0; s < 2; s++) begin
            slot_inst[s] = fetch_rsp_data_i[s*INST_W +: INST_W];
            slot_pc[s]   = {pc_q[INST_W-1:3], s[0], 2'b00};
            // Target is own address plus four times the signed offset
            slot_tgt[s]  = slot_pc[s] +
                           {{(INST_W-18){slot_inst[s][15]}}, slot_inst[s][15:0], 2'b00};
            case (decode_op(slot_inst[s][31:26]))
                OP_JUMP: begin
                    slot_br[s] = 1'b1;
                    slot_tk[s] = 1'b1;
                end
                OP_BCOND: begin
                    // Backward taken, forward not taken
                    slot_br[s] = 1'b1;
                    slot_tk[s] = slot_inst[s][15];
                end
                default: begin
                    slot_br[s] = 1'b0;
                    slot_tk[s] = 1'b0;
                end
            endcase
        end
    end

    // Redirect into the upper half skips the lower instruction
    assign skip0    = pc_q[2];
    assign rsp_take = (state_q == WAIT) && fetch_rsp_valid_i && !flush_i;

    // First written slot, lower half unless skipped
    assign wr0_en_o          = rsp_take;
    assign wr0_inst_o        = slot_inst[skip0];
    assign wr0_pc_o          = slot_pc[skip0];
    assign wr0_is_branch_o   = slot_br[skip0];
    assign wr0_pred_taken_o  = slot_tk[skip0];
    assign wr0_pred_target_o = slot_tgt[skip0];

    // Second slot dropped behind a predicted-taken branch
    assign wr1_en_o          = rsp_take && !skip0 && !slot_tk[0];
    assign wr1_inst_o        = slot_inst[1];
    assign wr1_pc_o          = slot_pc[1];
    assign wr1_is_branch_o   = slot_br[1];
    assign wr1_pred_taken_o  = slot_tk[1];
    assign wr1_pred_target_o = slot_tgt[1];

    always_comb begin
        if (wr0_pred_taken_o) begin
            next_pc = wr0_pred_target_o;
        end else if (wr1_en_o && slot_tk[1]) begin
            next_pc = slot_tgt[1];
        end else begin
            next_pc = {pc_q[INST_W-1:3] + 1'b1, 3'b000};
        end
    end

    //////////////////////////////////////////////////////////////////////
    // Request sequencing
    //////////////////////////////////////////////////////////////////////

    // Room for one pair, or two while a response is landing
    assign credit_idle = ibuf_count_i <= IBUF_CW'(IBUF_DEPTH - 2);
    assign credit_wait = ibuf_count_i <= IBUF_CW'(IBUF_DEPTH - 4);

    always_comb begin
        state_d = state_q;
        case (state_q)
            IDLE: begin
                if (run_i && credit_idle) begin
                    state_d = REQ;
                end
            end
            REQ: begin
                if (fetch_req_ready_i) begin
                    state_d = WAIT;
                end
            end
            WAIT: begin
                if (fetch_rsp_valid_i) begin
                    state_d = (run_i && credit_wait) ? REQ : IDLE;
                end
            end
            default: state_d = IDLE;
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset_i) begin
            state_q <= IDLE;
            pc_q    <= BOOT_PC;
        end else if (flush_i) begin
            // Outstanding read is dropped by leaving WAIT
            state_q <= IDLE;
            pc_q    <= {flush_pc_i[INST_W-1:2], 2'b00};
        end else begin
            state_q <= state_d;
            if (rsp_take) begin
                pc_q <= next_pc;
            end
        end
    end

    assign fetch_req_valid_o = (state_q == REQ);
    assign fetch_req_addr_o  = pc_q[MEM_AW+2:3];

endmodule

/* logic/inst_buffer.sv */
`timescale 1ns/1ps

module inst_buffer
    import frontend_pkg::*;
(
    input  logic               clk,
    input  logic               reset_i,
    input  logic               flush_i,

    // Write side from fetch
    input  logic               wr0_en_i,
    input  logic [INST_W-1:0]  wr0_inst_i,
    input  logic [INST_W-1:0]  wr0_pc_i,
    input  logic               wr0_is_branch_i,
    input  logic               wr0_pred_taken_i,
    input  logic [INST_W-1:0]  wr0_pred_target_i,
    input  logic               wr1_en_i,
    input  logic [INST_W-1:0]  wr1_inst_i,
    input  logic [INST_W-1:0]  wr1_pc_i,
    input  logic               wr1_is_branch_i,
    input  logic               wr1_pred_taken_i,
    input  logic [INST_W-1:0]  wr1_pred_target_i,
    output logic [IBUF_CW-1:0] count_o,

    // Issue side
    input  logic [1:0]         issue_ready_i,
    output logic               issue0_valid_o,
    output logic [INST_W-1:0]  issue0_inst_o,
    output logic [INST_W-1:0]  issue0_pc_o,
    output logic               issue0_is_branch_o,
    output logic               issue0_pred_taken_o,
    output logic [INST_W-1:0]  issue0_pred_target_o,
    output logic               issue1_valid_o,
    output logic [INST_W-1:0]  issue1_inst_o,
    output logic [INST_W-1:0]  issue1_pc_o,
    output logic               issue1_is_branch_o,
    output logic               issue1_pred_taken_o,
    output logic [INST_W-1:0]  issue1_pred_target_o
);

    // Entry storage
    logic [INST_W-1:0]     inst_q [IBUF_DEPTH];
    logic [INST_W-1:0]     pc_q   [IBUF_DEPTH];
    logic [INST_W-1:0]     tgt_q  [IBUF_DEPTH];
    logic [IBUF_DEPTH-1:0] br_q;
    logic [IBUF_DEPTH-1:0] tk_q;

    // Ring control
    logic [IBUF_AW-1:0] head_q;
    logic [IBUF_AW-1:0] tail_q;
    logic [IBUF_CW-1:0] count_q;
    logic [IBUF_AW-1:0] head1;
    logic [IBUF_AW-1:0] tail1;
    logic               pop0;
    logic               pop1;
    logic [IBUF_CW-1:0] n_push;
    logic [IBUF_CW-1:0] n_pop;

    assign head1 = head_q + 1'b1;
    assign tail1 = tail_q + 1'b1;

    //////////////////////////////////////////////////////////////////////
    // Show-ahead issue slots
    //////////////////////////////////////////////////////////////////////

    assign issue0_valid_o = (count_q != '0);
    assign issue1_valid_o = (count_q >= IBUF_CW'(2));

    assign issue0_inst_o        = inst_q[head_q];
    assign issue0_pc_o          = pc_q[head_q];
    assign issue0_is_branch_o   = br_q[head_q];
    assign issue0_pred_taken_o  = tk_q[head_q];
    assign issue0_pred_target_o = tgt_q[head_q];

    assign issue1_inst_o        = inst_q[head1];
    assign issue1_pc_o          = pc_q[head1];
    assign issue1_is_branch_o   = br_q[head1];
    assign issue1_pred_taken_o  = tk_q[head1];
    assign issue1_pred_target_o = tgt_q[head1];

    // Slot 1 only leaves together with slot 0, keeps order
    assign pop0 = issue0_valid_o && issue_ready_i[0];
    assign pop1 = pop0 && issue1_valid_o && issue_ready_i[1];

    assign n_pop  = IBUF_CW'(pop0) + IBUF_CW'(pop1);
    assign n_push = IBUF_CW'(wr0_en_i) + IBUF_CW'(wr1_en_i);

    //////////////////////////////////////////////////////////////////////
    // Pointers and occupancy
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (reset_i || flush_i) begin
            head_q  <= '0;
            tail_q  <= '0;
            count_q <= '0;
        end else begin
            head_q  <= head_q + IBUF_AW'(n_pop);
            tail_q  <= tail_q + IBUF_AW'(n_push);
            count_q <= count_q + n_push - n_pop;
        end
    end

    // Fetch holds off unless two entries are free
    always_ff @(posedge clk) begin
        if (wr0_en_i) begin
            inst_q[tail_q] <= wr0_inst_i;
            pc_q[tail_q]   <= wr0_pc_i;
            br_q[tail_q]   <= wr0_is_branch_i;
            tk_q[tail_q]   <= wr0_pred_taken_i;
            tgt_q[tail_q]  <= wr0_pred_target_i;
        end
        if (wr1_en_i) begin
            inst_q[tail1] <= wr1_inst_i;
            pc_q[tail1]   <= wr1_pc_i;
            br_q[tail1]   <= wr1_is_branch_i;
            tk_q[tail1]   <= wr1_pred_taken_i;
            tgt_q[tail1]  <= wr1_pred_target_i;
        end
    end

    assign count_o = count_q;

endmodule

/* logic/frontend_top.sv */
`timescale 1ns/1ps

module frontend_top
    import frontend_pkg::*;
(
    input  logic              clk,
    input  logic              reset_i,
    input  logic              run_i,
    input  logic              flush_i,
    input  logic [INST_W-1:0] flush_pc_i,

    input  logic              load_valid_i,
    output logic              load_ready_o,
    input  logic [MEM_AW-1:0] load_addr_i,
    input  logic [PAIR_W-1:0] load_data_i,

    input  logic [1:0]        issue_ready_i,
    output logic              issue0_valid_o,
    output logic [INST_W-1:0] issue0_inst_o,
    output logic [INST_W-1:0] issue0_pc_o,
    output logic              issue0_is_branch_o,
    output logic              issue0_pred_taken_o,
    output logic [INST_W-1:0] issue0_pred_target_o,
    output logic              issue1_valid_o,
    output logic [INST_W-1:0] issue1_inst_o,
    output logic [INST_W-1:0] issue1_pc_o,
    output logic              issue1_is_branch_o,
    output logic              issue1_pred_taken_o,
    output logic [INST_W-1:0] issue1_pred_target_o
);

    // Fetch to arbiter
    logic               fetch_req_valid;
    logic               fetch_req_ready;
    logic [MEM_AW-1:0]  fetch_req_addr;
    logic               fetch_rsp_valid;
    logic [PAIR_W-1:0]  fetch_rsp_data;

    // Arbiter to memory
    logic               mem_en;
    logic               mem_we;
    logic [MEM_AW-1:0]  mem_addr;
    logic [PAIR_W-1:0]  mem_wdata;
    logic [PAIR_W-1:0]  mem_rdata;

    // Fetch to buffer
    logic               wr0_en;
    logic [INST_W-1:0]  wr0_inst;
    logic [INST_W-1:0]  wr0_pc;
    logic               wr0_is_branch;
    logic               wr0_pred_taken;
    logic [INST_W-1:0]  wr0_pred_target;
    logic               wr1_en;
    logic [INST_W-1:0]  wr1_inst;
    logic [INST_W-1:0]  wr1_pc;
    logic               wr1_is_branch;
    logic               wr1_pred_taken;
    logic [INST_W-1:0]  wr1_pred_target;
    logic [IBUF_CW-1:0] ibuf_count;

    mem_arbiter mem_arbiter_i (
        .clk, .reset_i,
        .load_valid_i, .load_ready_o, .load_addr_i, .load_data_i,
        .fetch_req_valid_i (fetch_req_valid),
        .fetch_req_ready_o (fetch_req_ready),
        .fetch_req_addr_i  (fetch_req_addr),
        .fetch_rsp_valid_o (fetch_rsp_valid),
        .fetch_rsp_data_o  (fetch_rsp_data),
        .mem_en_o (mem_en), .mem_we_o (mem_we),
        .mem_addr_o (mem_addr), .mem_wdata_o (mem_wdata),
        .mem_rdata_i (mem_rdata)
    );

    inst_mem inst_mem_i (
        .clk,
        .en_i (mem_en), .we_i (mem_we), .addr_i (mem_addr),
        .wdata_i (mem_wdata), .rdata_o (mem_rdata)
    );

    fetch_unit fetch_unit_i (
        .clk, .reset_i, .run_i, .flush_i, .flush_pc_i,
        .fetch_req_valid_o (fetch_req_valid),
        .fetch_req_ready_i (fetch_req_ready),
        .fetch_req_addr_o  (fetch_req_addr),
        .fetch_rsp_valid_i (fetch_rsp_valid),
        .fetch_rsp_data_i  (fetch_rsp_data),
        .ibuf_count_i      (ibuf_count),
        .wr0_en_o (wr0_en), .wr0_inst_o (wr0_inst), .wr0_pc_o (wr0_pc),
        .wr0_is_branch_o (wr0_is_branch), .wr0_pred_taken_o (wr0_pred_taken),
        .wr0_pred_target_o (wr0_pred_target),
        .wr1_en_o (wr1_en), .wr1_inst_o (wr1_inst), .wr1_pc_o (wr1_pc),
        .wr1_is_branch_o (wr1_is_branch), .wr1_pred_taken_o (wr1_pred_taken),
        .wr1_pred_target_o (wr1_pred_target)
    );

    inst_buffer inst_buffer_i (
        .clk, .reset_i, .flush_i,
        .wr0_en_i (wr0_en), .wr0_inst_i (wr0_inst), .wr0_pc_i (wr0_pc),
        .wr0_is_branch_i (wr0_is_branch), .wr0_pred_taken_i (wr0_pred_taken),
        .wr0_pred_target_i (wr0_pred_target),
        .wr1_en_i (wr1_en), .wr1_inst_i (wr1_inst), .wr1_pc_i (wr1_pc),
        .wr1_is_branch_i (wr1_is_branch), .wr1_pred_taken_i (wr1_pred_taken),
        .wr1_pred_target_i (wr1_pred_target),
        .count_o (ibuf_count),
        .issue_ready_i,
        .issue0_valid_o, .issue0_inst_o, .issue0_pc_o,
        .issue0_is_branch_o, .issue0_pred_taken_o, .issue0_pred_target_o,
        .issue1_valid_o, .issue1_inst_o, .issue1_pc_o,
        .issue1_is_branch_o, .issue1_pred_taken_o, .issue1_pred_target_o
    );

endmodule

/* dv/frontend_properties.sv */
`timescale 1ns/1ps

module frontend_properties
    import frontend_pkg::*;
(
    input  logic               clk,
    input  logic               reset_i,
    input  logic               flush_i,
    input  logic [IBUF_CW-1:0] count_i,
    input  logic [1:0]         ready_i,
    input  logic               valid0_i,
    input  logic [INST_W-1:0]  inst0_i,
    input  logic [INST_W-1:0]  pc0_i,
    input  logic [INST_W-1:0]  tgt0_i,
    input  logic               tk0_i,
    input  logic               valid1_i,
    input  logic [INST_W-1:0]  inst1_i,
    input  logic [INST_W-1:0]  pc1_i,
    input  logic [INST_W-1:0]  tgt1_i
);

    // Set once any property below has failed
    logic violation_seen = 1'b0;

    // Occupancy never above the ring size
    count_bound: assert property (@(posedge clk) disable iff (reset_i)
        count_i <= IBUF_CW'(IBUF_DEPTH))
        else begin
            $error("buffer count exceeds depth");
            violation_seen = 1'b1;
        end

    // Held slot 0 keeps its contents
    slot0_hold: assert property (@(posedge clk) disable iff (reset_i)
        valid0_i && !ready_i[0] && !flush_i |=> $stable({inst0_i, pc0_i, tgt0_i}))
        else begin
            $error("slot 0 changed while stalled");
            violation_seen = 1'b1;
        end

    // Slot 1 cannot move while slot 0 holds
    slot1_hold: assert property (@(posedge clk) disable iff (reset_i)
        valid1_i && !ready_i[0] && !flush_i |=> $stable({inst1_i, pc1_i, tgt1_i}))
        else begin
            $error("slot 1 changed while stalled");
            violation_seen = 1'b1;
        end

    // Slot 1 sits behind slot 0 and holds its predicted successor
    slot1_order: assert property (@(posedge clk) disable iff (reset_i)
        valid1_i |-> valid0_i && (pc1_i == (tk0_i ? tgt0_i : pc0_i + 32'd4)))
        else begin
            $error("slot 1 valid without slot 0 or out of program order");
            violation_seen = 1'b1;
        end

    flush_empty: assert property (@(posedge clk) disable iff (reset_i)
        flush_i |=> !valid0_i && !valid1_i)
        else begin
            $error("issue valid one cycle after flush");
            violation_seen = 1'b1;
        end

endmodule

/* dv/frontend_tb.sv */
`timescale 1ns/1ps

module frontend_tb
    import frontend_pkg::*;
();

    // Entry layout is pc, inst, target, is_branch, pred_taken
    typedef logic [3*INST_W+1:0] entry_t;

    // 40 cycles per expected instruction over all tests
    localparam int TOTAL_INST     = 24 + 22 + 12 + 64 + 24 + 48;
    localparam int TIMEOUT_CYCLES = 40 * TOTAL_INST;

    logic              clk;
    logic              reset_i;
    logic              run_i;
    logic              flush_i;
    logic [INST_W-1:0] flush_pc_i;
    logic              load_valid_i;
    logic              load_ready_o;
    logic [MEM_AW-1:0] load_addr_i;
    logic [PAIR_W-1:0] load_data_i;
    logic [1:0]        issue_ready_i;
    logic              issue0_valid_o;
    logic [INST_W-1:0] issue0_inst_o;
    logic [INST_W-1:0] issue0_pc_o;
    logic              issue0_is_branch_o;
    logic              issue0_pred_taken_o;
    logic [INST_W-1:0] issue0_pred_target_o;
    logic              issue1_valid_o;
    logic [INST_W-1:0] issue1_inst_o;
    logic [INST_W-1:0] issue1_pc_o;
    logic              issue1_is_branch_o;
    logic              issue1_pred_taken_o;
    logic [INST_W-1:0] issue1_pred_target_o;

    // Reference image of the instruction memory
    logic [PAIR_W-1:0] model_mem [MEM_DEPTH];
    entry_t            exp_q [$];
    entry_t            seen_q [$];
    integer            seed = 32'h410a_7e49;
    int                cycle_cnt = 0;

    frontend_top frontend_top_i (.*);

    bind inst_buffer frontend_properties props_i (
        .clk      (clk),
        .reset_i  (reset_i),
        .flush_i  (flush_i),
        .count_i  (count_o),
        .ready_i  (issue_ready_i),
        .valid0_i (issue0_valid_o),
        .inst0_i  (issue0_inst_o),
        .pc0_i    (issue0_pc_o),
        .tgt0_i   (issue0_pred_target_o),
        .tk0_i    (issue0_pred_taken_o),
        .valid1_i (issue1_valid_o),
        .inst1_i  (issue1_inst_o),
        .pc1_i    (issue1_pc_o),
        .tgt1_i   (issue1_pred_target_o)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    always @(posedge clk) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt >= TIMEOUT_CYCLES) begin
            $display("Timeout: the expected instructions did not all issue in time");
            $display("Test failures found");
            $fatal(1, "run stopped by cycle limit");
        end
    end

    always @(negedge clk) begin
        if (frontend_top_i.inst_buffer_i.props_i.violation_seen) begin
            $display("A bound assertion on the instruction buffer failed");
            $display("Test failures found");
            $fatal(1, "run stopped by assertion failure");
        end
    end

    // Record every instruction that leaves through the issue port
    always @(negedge clk) begin
        if (!reset_i && issue0_valid_o && issue_ready_i[0]) begin
            seen_q.push_back({issue0_pc_o, issue0_inst_o, issue0_pred_target_o,
                              issue0_is_branch_o, issue0_pred_taken_o});
            if (issue1_valid_o && issue_ready_i[1]) begin
                seen_q.push_back({issue1_pc_o, issue1_inst_o, issue1_pred_target_o,
                                  issue1_is_branch_o, issue1_pred_taken_o});
            end
        end
    end

    //////////////////////////////////////////////////////////////////////
    // Helpers
    //////////////////////////////////////////////////////////////////////

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        if (got !== exp) begin
            $display("MISMATCH at %0d ns: %s got %h expected %h", $time, name, got, exp);
            $display("Test failures found");
            $fatal(1, "stopped at first error");
        end
    endtask

    function automatic logic [31:0] fill_word(input logic [8:0] word_addr);
        // Ordinary opcode with the word address in the low bits
        fill_word = {6'h08, 17'h00000, word_addr};
    endfunction

    function automatic logic [31:0] make_branch(input logic [5:0] op, input int off);
        make_branch = {op, 10'h000, off[15:0]};
    endfunction

    task automatic load_pair(input logic [MEM_AW-1:0] addr, input logic [PAIR_W-1:0] data);
        model_mem[addr] = data;
        @(posedge clk);
        #2;
        load_valid_i = 1'b1;
        load_addr_i  = addr;
        load_data_i  = data;
        check_value("load_ready_o", 32'(load_ready_o), 32'd1);
        @(posedge clk);
        #2;
        load_valid_i = 1'b0;
    endtask

    task automatic write_inst(input logic [31:0] pc, input logic [31:0] inst);
        logic [PAIR_W-1:0] pair;
        pair = model_mem[pc[10:3]];
        if (pc[2]) begin
            pair[63:32] = inst;
        end else begin
            pair[31:0] = inst;
        end
        load_pair(pc[10:3], pair);
    endtask

    task automatic fill_memory();
        for (int p = 0; p < MEM_DEPTH; p++) begin
            load_pair(p[7:0], {fill_word({p[7:0], 1'b1}), fill_word({p[7:0], 1'b0})});
        end
    endtask

    // Stop fetch, empty the buffer and point fetch at a new address
    task automatic restart_at(input logic [31:0] pc);
        @(posedge clk);
        #2;
        run_i         = 1'b0;
        issue_ready_i = 2'b00;
        flush_i       = 1'b1;
        flush_pc_i    = pc;
        @(posedge clk);
        #2;
        flush_i = 1'b0;
        seen_q.delete();
    endtask

    task automatic run_stream(input int n, input bit random_ready);
        logic [31:0] rnd;
        while (seen_q.size() < n) begin
            @(posedge clk);
            #2;
            if (random_ready) begin
                rnd           = $random(seed);
                issue_ready_i = rnd[1:0];
            end else begin
                issue_ready_i = 2'b11;
            end
        end
    endtask

    // Walk the image one instruction at a time with the static predictor
    task automatic predict_stream(input logic [31:0] start_pc, input int n);
        logic [31:0] pc;
        logic [31:0] inst;
        logic [31:0] tgt;
        logic [5:0]  op;
        logic        br;
        logic        tk;
        pc = start_pc;
        exp_q.delete();
        for (int i = 0; i < n; i++) begin
            inst = pc[2] ? model_mem[pc[10:3]][63:32] : model_mem[pc[10:3]][31:0];
            op   = inst[31:26];
            br   = (op == OP_JUMP) || (op == OP_BCOND);
            // Conditional branches predicted taken only backward
            tk   = (op == OP_JUMP) || ((op == OP_BCOND) && inst[15]);
            tgt  = pc + 4 * 32'($signed(inst[15:0]));
            exp_q.push_back({pc, inst, tgt, br, tk});
            pc   = tk ? tgt : pc + 32'd4;
        end
    endtask

    task automatic compare_stream(input int n);
        entry_t got;
        entry_t exp;
        for (int i = 0; i < n; i++) begin
            got = seen_q[i];
            exp = exp_q[i];
            check_value("issue_pc_o", got[97:66], exp[97:66]);
            check_value("issue_inst_o", got[65:34], exp[65:34]);
            check_value("issue_is_branch_o", 32'(got[1]), 32'(exp[1]));
            check_value("issue_pred_taken_o", 32'(got[0]), 32'(exp[0]));
            if (exp[1]) begin
                check_value("issue_pred_target_o", got[33:2], exp[33:2]);
            end
        end
    endtask

    //////////////////////////////////////////////////////////////////////
    // Directed tests
    //////////////////////////////////////////////////////////////////////

    task automatic straight_line_stream();
        restart_at(32'h100);
        run_i = 1'b1;
        run_stream(24, 1'b0);
        predict_stream(32'h100, 24);
        compare_stream(24);
    endtask

    task automatic cond_branch_redirect();
        // Backward branch in the lower half loops to an odd slot
        restart_at(32'h200);
        write_inst(32'h210, make_branch(OP_BCOND, -3));
        run_i = 1'b1;
        run_stream(12, 1'b0);
        predict_stream(32'h200, 12);
        compare_stream(12);
        // Forward branch falls through
        restart_at(32'h300);
        write_inst(32'h308, make_branch(OP_BCOND, 5));
        run_i = 1'b1;
        run_stream(10, 1'b0);
        predict_stream(32'h300, 10);
        compare_stream(10);
    endtask

    task automatic jump_to_odd_slot();
        restart_at(32'h400);
        write_inst(32'h408, make_branch(OP_JUMP, 7));
        write_inst(32'h42c, make_branch(OP_JUMP, -11));
        run_i = 1'b1;
        run_stream(12, 1'b0);
        predict_stream(32'h400, 12);
        compare_stream(12);
    endtask

    task automatic random_backpressure();
        restart_at(32'h500);
        write_inst(32'h550, make_branch(OP_BCOND, -6));
        run_i = 1'b1;
        // With nothing issuing fetch runs until the buffer is full
        repeat (40) @(posedge clk);
        #2;
        check_value("count_o", 32'(frontend_top_i.inst_buffer_i.count_o), IBUF_DEPTH);
        run_stream(64, 1'b1);
        predict_stream(32'h500, 64);
        compare_stream(64);
    endtask

    task automatic flush_restart();
        restart_at(32'h600);
        run_i = 1'b1;
        run_stream(8, 1'b0);
        predict_stream(32'h600, 8);
        compare_stream(8);
        @(posedge clk);
        #2;
        issue_ready_i = 2'b00;
        // Let entries pile up so the flush has something to clear
        while (!issue1_valid_o) begin
            @(posedge clk);
            #2;
        end
        flush_i    = 1'b1;
        flush_pc_i = 32'h6a0;
        @(posedge clk);
        #2;
        flush_i = 1'b0;
        check_value("issue0_valid_o", 32'(issue0_valid_o), 32'd0);
        check_value("issue1_valid_o", 32'(issue1_valid_o), 32'd0);
        seen_q.delete();
        run_stream(16, 1'b0);
        predict_stream(32'h6a0, 16);
        compare_stream(16);
    endtask

    task automatic load_during_fetch();
        restart_at(32'h700);
        run_i         = 1'b1;
        issue_ready_i = 2'b11;
        fork
            begin
                // New code well ahead of fetch ends in a jump back to the start
                for (int k = 0; k < 7; k++) begin
                    write_inst(32'h780 + 4 * k, {6'h0c, 18'h00000, 8'(k)});
                end
                write_inst(32'h79c, make_branch(OP_JUMP, -39));
            end
            run_stream(48, 1'b0);
        join
        predict_stream(32'h700, 48);
        compare_stream(48);
    endtask

    initial begin
        reset_i       = 1'b1;
        run_i         = 1'b0;
        flush_i       = 1'b0;
        flush_pc_i    = '0;
        load_valid_i  = 1'b0;
        load_addr_i   = '0;
        load_data_i   = '0;
        issue_ready_i = 2'b00;
        repeat (16) @(posedge clk);
        #2;
        reset_i = 1'b0;
        fill_memory();
        straight_line_stream();
        cond_branch_redirect();
        jump_to_odd_slot();
        random_backpressure();
        flush_restart();
        load_during_fetch();
        if (frontend_top_i.inst_buffer_i.props_i.violation_seen) begin
            $display("A bound assertion on the instruction buffer failed");
            $display("Test failures found");
            $fatal(1, "run stopped by assertion failure");
        end else begin
            $display("All tests passed!");
            $finish;
        end
    end

endmodule

/* flist.f */
logic/frontend_pkg.sv
logic/inst_mem.sv
logic/mem_arbiter.sv
logic/fetch_unit.sv
logic/inst_buffer.sv
logic/frontend_top.sv
dv/frontend_properties.sv
dv/frontend_tb.sv

/* Bender.yml */
package:
  name: frontend

sources:
  - logic/frontend_pkg.sv
  - logic/inst_mem.sv
  - logic/mem_arbiter.sv
  - logic/fetch_unit.sv
  - logic/inst_buffer.sv
  - logic/frontend_top.sv
  - target: test
    files:
      - dv/frontend_properties.sv
      - dv/frontend_tb.sv
